// File: source/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// data and address width
`define XLEN 32

// first fetch address
`define RESET_PC 32'h0000_0000

// history table size, indexed by pc above bit 1
`define BHT_ENTRIES 16

// return address stack size
`define RAS_DEPTH 4

// addi x0, x0, 0
`define NOP 32'h0000_0013

`endif

// File: source/rv_isa_pkg.sv
`include "fetch_params.svh"

package rv_isa_pkg;

    // control-flow class of the fetched word
    typedef enum logic [1:0] {
        cf_none   = 2'b00,
        cf_jal    = 2'b01,
        cf_jalr   = 2'b10,
        cf_branch = 2'b11
    } cf_kind_t;

    // same encoding as funct3 of the branch opcode
    typedef enum logic [2:0] {
        cond_eq  = 3'b000,
        cond_ne  = 3'b001,
        cond_lt  = 3'b100,
        cond_ge  = 3'b101,
        cond_ltu = 3'b110,
        cond_geu = 3'b111
    } br_cond_t;

    // decoded control instruction, imm already sign-extended
    typedef struct packed {
        cf_kind_t              kind;
        br_cond_t              cond;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [4:0]            rd;
        logic [`XLEN-1:0]      imm;
    } cf_instr_t;

endpackage

// File: source/pipe_pkg.sv
`include "fetch_params.svh"

package pipe_pkg;

    // destination info of one later stage
    typedef struct packed {
        logic [4:0] rd;
        logic       reg_write;
        logic       mem_read;
    } stage_hz_t;

    // operand source
    typedef enum logic [1:0] {
        fwd_regfile = 2'b00,
        fwd_mem     = 2'b01,
        fwd_wb      = 2'b10
    } fwd_sel_t;

    // correction from a later stage
    typedef struct packed {
        logic             flush;
        logic [`XLEN-1:0] pc;
    } redirect_t;

    // branch outcome known later, trains the history table
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic             taken;
    } bht_train_t;

endpackage

// File: source/mini_decode.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module mini_decode (
    input  logic [`XLEN-1:0]      instr_i,
    output rv_isa_pkg::cf_instr_t cf_o
);
    import rv_isa_pkg::*;

    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_b;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];

    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

    // unused register fields stay zero so they never raise a hazard
    always_comb begin
        cf_o = '0;
        cf_o.kind = cf_none;
        cf_o.cond = cond_eq;
        case (opcode)
            OP_JAL: begin
                cf_o.kind = cf_jal;
                cf_o.rd   = instr_i[11:7];
                cf_o.imm  = imm_j;
            end
            OP_JALR: begin
                if (funct3 == 3'b000) begin
                    cf_o.kind = cf_jalr;
                    cf_o.rs1  = instr_i[19:15];
                    cf_o.rd   = instr_i[11:7];
                    cf_o.imm  = imm_i;
                end
            end
            OP_BRANCH: begin
                // funct3 010 and 011 are not branches
                if (funct3[2:1] != 2'b01) begin
                    cf_o.kind = cf_branch;
                    cf_o.cond = br_cond_t'(funct3);
                    cf_o.rs1  = instr_i[19:15];
                    cf_o.rs2  = instr_i[24:20];
                    cf_o.imm  = imm_b;
                end
            end
            default: begin
                cf_o.kind = cf_none;
            end
        endcase
    end

endmodule

// File: source/fetch_control.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_control (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  rv_isa_pkg::cf_instr_t cf_i,
    input  pipe_pkg::stage_hz_t   id_hz_i,
    input  pipe_pkg::stage_hz_t   ex_hz_i,
    input  pipe_pkg::stage_hz_t   mem_hz_i,
    input  pipe_pkg::stage_hz_t   wb_hz_i,
    input  logic                  ras_valid_i,
    input  logic                  pc_advance_i,
    output pipe_pkg::fwd_sel_t    rs1_sel_o,
    output pipe_pkg::fwd_sel_t    rs2_sel_o,
    output logic                  use_pred_o,
    output logic                  ras_push_o,
    output logic                  ras_pop_o,
    output logic                  stall_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic rs1_ready;
    logic rs2_ready;
    logic is_jal;
    logic is_jalr;
    logic is_branch;
    logic ret_hit;
    logic stall_raw;
    logic init_q;

    function automatic logic hz_hit(input stage_hz_t hz, input logic [4:0] rs);
        hz_hit = (hz.rd != 5'd0) && (hz.rd == rs);
    endfunction

    // value still in flight: id writer, or a load in ex
    function automatic logic op_ready(input logic [4:0] rs);
        op_ready = !(hz_hit(id_hz_i, rs) && id_hz_i.reg_write) &&
                   !(hz_hit(ex_hz_i, rs) && ex_hz_i.mem_read);
    endfunction

    function automatic fwd_sel_t pick_src(input logic [4:0] rs);
        if (hz_hit(mem_hz_i, rs) && mem_hz_i.reg_write && !mem_hz_i.mem_read) begin
            pick_src = fwd_mem;
        end else if (hz_hit(wb_hz_i, rs) && wb_hz_i.reg_write) begin
            pick_src = fwd_wb;
        end else begin
            pick_src = fwd_regfile;
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // readiness and forwarding
    ////////////////////////////////////////////////////////////

    assign rs1_ready = op_ready(cf_i.rs1);
    assign rs2_ready = op_ready(cf_i.rs2);
    assign rs1_sel_o = pick_src(cf_i.rs1);
    assign rs2_sel_o = pick_src(cf_i.rs2);

    assign is_jal    = (cf_i.kind == cf_jal);
    assign is_jalr   = (cf_i.kind == cf_jalr);
    assign is_branch = (cf_i.kind == cf_branch);

    ////////////////////////////////////////////////////////////
    // resolve, predict or stall
    ////////////////////////////////////////////////////////////

    // return through x1 with a saved address
    assign ret_hit = is_jalr && !rs1_ready && (cf_i.rs1 == 5'd1) && ras_valid_i;

    assign use_pred_o = (is_branch && !(rs1_ready && rs2_ready)) || ret_hit;
    assign stall_raw  = is_jalr && !rs1_ready && !ret_hit;

    assign ras_push_o = is_jal && (cf_i.rd == 5'd1) && pc_advance_i;
    assign ras_pop_o  = ret_hit && pc_advance_i;

    // first cycle out of reset never stalls
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            init_q <= 1'b1;
        end else begin
            init_q <= 1'b0;
        end
    end

    assign stall_o = stall_raw && !init_q;

endmodule

// File: source/branch_predictor.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module branch_predictor (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic [`XLEN-1:0]     pc_i,
    input  pipe_pkg::bht_train_t train_i,
    input  logic                 push_i,
    input  logic                 pop_i,
    input  logic [`XLEN-1:0]     push_addr_i,
    output logic                 pred_taken_o,
    output logic [`XLEN-1:0]     ras_top_o,
    output logic                 ras_valid_o
);
    import pipe_pkg::*;

    localparam int IDX_W = $clog2(`BHT_ENTRIES);
    localparam int PTR_W = $clog2(`RAS_DEPTH);
    localparam int CNT_W = $clog2(`RAS_DEPTH + 1);

    logic [1:0]         bht_q [`BHT_ENTRIES];
    logic [IDX_W-1:0]   rd_idx;
    logic [IDX_W-1:0]   wr_idx;

    logic [`XLEN-1:0]   ras_q [`RAS_DEPTH];
    logic [PTR_W-1:0]   tos_q;
    logic [CNT_W-1:0]   count_q;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(`RAS_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    function automatic logic [PTR_W-1:0] ptr_dec(input logic [PTR_W-1:0] p);
        ptr_dec = (p == '0) ? PTR_W'(`RAS_DEPTH - 1) : p - 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////
    // branch history table
    ////////////////////////////////////////////////////////////

    assign rd_idx = pc_i[IDX_W+1:2];
    assign wr_idx = train_i.pc[IDX_W+1:2];

    // upper counter bit is the prediction
    assign pred_taken_o = bht_q[rd_idx][1];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                bht_q[i] <= 2'b01;
            end
        end else if (train_i.valid) begin
            if (train_i.taken && (bht_q[wr_idx] != 2'b11)) begin
                bht_q[wr_idx] <= bht_q[wr_idx] + 2'b01;
            end else if (!train_i.taken && (bht_q[wr_idx] != 2'b00)) begin
                bht_q[wr_idx] <= bht_q[wr_idx] - 2'b01;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // return address stack
    ////////////////////////////////////////////////////////////

    assign ras_top_o   = ras_q[tos_q];
    assign ras_valid_o = (count_q != '0);

    // circular, so a push when full overwrites the oldest slot
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            tos_q   <= '0;
            count_q <= '0;
        end else if (push_i) begin
            tos_q <= ptr_inc(tos_q);
            if (count_q != CNT_W'(`RAS_DEPTH)) begin
                count_q <= count_q + 1'b1;
            end
        end else if (pop_i && ras_valid_o) begin
            tos_q   <= ptr_dec(tos_q);
            count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            ras_q[ptr_inc(tos_q)] <= push_addr_i;
        end
    end

endmodule

// File: source/branch_resolve.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module branch_resolve (
    input  logic [`XLEN-1:0]   rs1_data_i,
    input  logic [`XLEN-1:0]   rs2_data_i,
    input  logic [`XLEN-1:0]   mem_result_i,
    input  logic [`XLEN-1:0]   wb_result_i,
    input  pipe_pkg::fwd_sel_t rs1_sel_i,
    input  pipe_pkg::fwd_sel_t rs2_sel_i,
    input  rv_isa_pkg::br_cond_t cond_i,
    output logic [`XLEN-1:0]   rs1_val_o,
    output logic               taken_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;

    function automatic logic [`XLEN-1:0] fwd_mux(input fwd_sel_t sel,
                                                 input logic [`XLEN-1:0] rf_val);
        case (sel)
            fwd_mem: fwd_mux = mem_result_i;
            fwd_wb:  fwd_mux = wb_result_i;
            default: fwd_mux = rf_val;
        endcase
    endfunction

    assign op_a      = fwd_mux(rs1_sel_i, rs1_data_i);
    assign op_b      = fwd_mux(rs2_sel_i, rs2_data_i);
    assign rs1_val_o = op_a;

    // comparator
    always_comb begin
        case (cond_i)
            cond_eq:  taken_o = (op_a == op_b);
            cond_ne:  taken_o = (op_a != op_b);
            cond_lt:  taken_o = ($signed(op_a) < $signed(op_b));
            cond_ge:  taken_o = ($signed(op_a) >= $signed(op_b));
            cond_ltu: taken_o = (op_a < op_b);
            cond_geu: taken_o = (op_a >= op_b);
            default:  taken_o = 1'b0;
        endcase
    end

endmodule

// File: source/pc_unit.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module pc_unit (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  rv_isa_pkg::cf_instr_t cf_i,
    input  logic                  resolved_taken_i,
    input  logic                  pred_taken_i,
    input  logic                  use_pred_i,
    input  logic [`XLEN-1:0]      rs1_val_i,
    input  logic [`XLEN-1:0]      ras_top_i,
    input  logic                  hold_i,
    input  pipe_pkg::redirect_t   redirect_i,
    output logic [`XLEN-1:0]      pc_o,
    output logic [`XLEN-1:0]      pc_plus4_o,
    output logic                  taken_o,
    output logic                  advance_o
);
    import rv_isa_pkg::*;

    localparam logic [`XLEN-1:0] PC_STEP = 4;

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] pc_next;
    logic [`XLEN-1:0] rel_target;
    logic [`XLEN-1:0] jalr_sum;
    logic [`XLEN-1:0] jalr_target;

    assign pc_o       = pc_q;
    assign pc_plus4_o = pc_q + PC_STEP;

    assign taken_o = (cf_i.kind == cf_branch) && (use_pred_i ? pred_taken_i : resolved_taken_i);

    // jal and branches share the pc-relative adder
    assign rel_target  = pc_q + cf_i.imm;
    assign jalr_sum    = rs1_val_i + cf_i.imm;
    assign jalr_target = use_pred_i ? ras_top_i : {jalr_sum[`XLEN-1:1], 1'b0};

    assign advance_o = !redirect_i.flush && !hold_i;

    always_comb begin
        if (redirect_i.flush) begin
            pc_next = redirect_i.pc;
        end else if (hold_i) begin
            pc_next = pc_q;
        end else if (cf_i.kind == cf_jal) begin
            pc_next = rel_target;
        end else if (cf_i.kind == cf_jalr) begin
            pc_next = jalr_target;
        end else if (taken_o) begin
            pc_next = rel_target;
        end else begin
            pc_next = pc_plus4_o;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= `RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic [`XLEN-1:0]     instr_i,
    output logic [`XLEN-1:0]     pc_o,
    output logic [`XLEN-1:0]     instr_o,
    output logic [4:0]           rs1_addr_o,
    output logic [4:0]           rs2_addr_o,
    input  logic [`XLEN-1:0]     rs1_data_i,
    input  logic [`XLEN-1:0]     rs2_data_i,
    input  logic [`XLEN-1:0]     mem_result_i,
    input  logic [`XLEN-1:0]     wb_result_i,
    input  pipe_pkg::stage_hz_t  id_hz_i,
    input  pipe_pkg::stage_hz_t  ex_hz_i,
    input  pipe_pkg::stage_hz_t  mem_hz_i,
    input  pipe_pkg::stage_hz_t  wb_hz_i,
    input  logic                 stall_i,
    input  pipe_pkg::redirect_t  redirect_i,
    input  pipe_pkg::bht_train_t train_i,
    output logic                 stall_o,
    output logic                 taken_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    cf_instr_t        cf;
    fwd_sel_t         rs1_sel;
    fwd_sel_t         rs2_sel;
    logic             use_pred;
    logic             ras_push;
    logic             ras_pop;
    logic             ras_valid;
    logic [`XLEN-1:0] ras_top;
    logic             pred_taken;
    logic             resolved_taken;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] pc_plus4;
    logic             pc_advance;
    logic             hold;

    assign rs1_addr_o = cf.rs1;
    assign rs2_addr_o = cf.rs2;
    assign hold       = stall_i | stall_o;

    // bubble to decode while fetch waits on a jalr
    assign instr_o = stall_o ? `NOP : instr_i;

    mini_decode mini_decode_inst (
        .instr_i (instr_i),
        .cf_o    (cf)
    );

    fetch_control fetch_control_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .cf_i         (cf),
        .id_hz_i      (id_hz_i),
        .ex_hz_i      (ex_hz_i),
        .mem_hz_i     (mem_hz_i),
        .wb_hz_i      (wb_hz_i),
        .ras_valid_i  (ras_valid),
        .pc_advance_i (pc_advance),
        .rs1_sel_o    (rs1_sel),
        .rs2_sel_o    (rs2_sel),
        .use_pred_o   (use_pred),
        .ras_push_o   (ras_push),
        .ras_pop_o    (ras_pop),
        .stall_o      (stall_o)
    );

    branch_resolve branch_resolve_inst (
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .mem_result_i (mem_result_i),
        .wb_result_i  (wb_result_i),
        .rs1_sel_i    (rs1_sel),
        .rs2_sel_i    (rs2_sel),
        .cond_i       (cf.cond),
        .rs1_val_o    (rs1_val),
        .taken_o      (resolved_taken)
    );

    branch_predictor branch_predictor_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pc_i         (pc_o),
        .train_i      (train_i),
        .push_i       (ras_push),
        .pop_i        (ras_pop),
        .push_addr_i  (pc_plus4),
        .pred_taken_o (pred_taken),
        .ras_top_o    (ras_top),
        .ras_valid_o  (ras_valid)
    );

    pc_unit pc_unit_inst (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .cf_i             (cf),
        .resolved_taken_i (resolved_taken),
        .pred_taken_i     (pred_taken),
        .use_pred_i       (use_pred),
        .rs1_val_i        (rs1_val),
        .ras_top_i        (ras_top),
        .hold_i           (hold),
        .redirect_i       (redirect_i),
        .pc_o             (pc_o),
        .pc_plus4_o       (pc_plus4),
        .taken_o          (taken_o),
        .advance_o        (pc_advance)
    );

endmodule

// File: verif/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_tb;
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    typedef struct packed {
        cf_kind_t         kind;
        logic [2:0]       f3;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [4:0]       rd;
        logic [`XLEN-1:0] imm;
    } op_t;

    // everything the rest of the pipeline shows the stage in one cycle
    typedef struct packed {
        op_t              op;
        logic [`XLEN-1:0] rs1_data;
        logic [`XLEN-1:0] rs2_data;
        logic [`XLEN-1:0] mem_res;
        logic [`XLEN-1:0] wb_res;
        stage_hz_t        id;
        stage_hz_t        ex;
        stage_hz_t        mem;
        stage_hz_t        wb;
        logic             stall;
        redirect_t        redir;
        bht_train_t       train;
    } cyc_t;

    typedef struct packed {
        logic [`XLEN-1:0] next_pc;
        logic [`XLEN-1:0] instr;
        logic             taken;
        logic             stall;
        logic             push;
        logic             pop;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
    } exp_t;

    // expected values next to what the DUT showed before the edge
    typedef struct packed {
        exp_t             e;
        logic [`XLEN-1:0] cur_pc;
        logic [`XLEN-1:0] got_pc;
        logic [`XLEN-1:0] got_instr;
        logic             got_taken;
        logic             got_stall;
        logic [4:0]       got_rs1;
        logic [4:0]       got_rs2;
    } chk_t;

    logic             clk = 1'b0;
    logic             rst_n_i;
    logic [`XLEN-1:0] instr_i;
    logic [`XLEN-1:0] pc_o;
    logic [`XLEN-1:0] instr_o;
    logic [4:0]       rs1_addr_o;
    logic [4:0]       rs2_addr_o;
    logic [`XLEN-1:0] rs1_data_i;
    logic [`XLEN-1:0] rs2_data_i;
    logic [`XLEN-1:0] mem_result_i;
    logic [`XLEN-1:0] wb_result_i;
    stage_hz_t        id_hz_i;
    stage_hz_t        ex_hz_i;
    stage_hz_t        mem_hz_i;
    stage_hz_t        wb_hz_i;
    logic             stall_i;
    redirect_t        redirect_i;
    bht_train_t       train_i;
    logic             stall_o;
    logic             taken_o;

    // reference state: pc, history counters, return stack
    logic [`XLEN-1:0] model_pc;
    logic [1:0]       bht_m [`BHT_ENTRIES];
    logic [`XLEN-1:0] ras_m [`RAS_DEPTH];
    int               ras_tos;
    int               ras_cnt;
    chk_t             chk_q [$];
    int               err_cnt = 0;
    logic             seen_stall;

    fetch_stage dut0 (.*);

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] encode(input op_t op);
        case (op.kind)
            cf_jal:    encode = {op.imm[20], op.imm[10:1], op.imm[11], op.imm[19:12], op.rd,
                                 7'b1101111};
            cf_jalr:   encode = {op.imm[11:0], op.rs1, 3'b000, op.rd, 7'b1100111};
            cf_branch: encode = {op.imm[12], op.imm[10:5], op.rs2, op.rs1, op.f3,
                                 op.imm[4:1], op.imm[11], 7'b1100011};
            default:   encode = `NOP;
        endcase
    endfunction

    // word aligned, fits an immediate of the given width
    function automatic logic [31:0] rand_imm(input int bits);
        int r;
        r = int'($urandom % (1 << (bits - 3))) - (1 << (bits - 4));
        rand_imm = 32'(r * 4);
    endfunction

    function automatic stage_hz_t rand_hz(input logic [4:0] a, input logic [4:0] b);
        stage_hz_t hz;
        case ($urandom % 3)
            0:       hz.rd = a;
            1:       hz.rd = b;
            default: hz.rd = 5'($urandom);
        endcase
        hz.reg_write = 1'($urandom);
        hz.mem_read  = 1'($urandom);
        return hz;
    endfunction

    function automatic cyc_t idle_cycle();
        cyc_t c;
        c = '0;
        c.op.kind = cf_none;
        return c;
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic logic hits(input stage_hz_t hz, input logic [4:0] rs);
        return (hz.rd != 5'd0) && (hz.rd == rs);
    endfunction

    function automatic logic ready(input cyc_t c, input logic [4:0] rs);
        return !(hits(c.id, rs) && c.id.reg_write) && !(hits(c.ex, rs) && c.ex.mem_read);
    endfunction

    function automatic logic [31:0] operand(input cyc_t c, input logic [4:0] rs,
                                            input logic [31:0] rf);
        operand = (hits(c.mem, rs) && c.mem.reg_write && !c.mem.mem_read) ? c.mem_res :
                  (hits(c.wb, rs) && c.wb.reg_write) ? c.wb_res : rf;
    endfunction

    function automatic logic cond_holds(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'b000:  cond_holds = (a == b);
            3'b001:  cond_holds = (a != b);
            3'b100:  cond_holds = ($signed(a) < $signed(b));
            3'b101:  cond_holds = ($signed(a) >= $signed(b));
            3'b110:  cond_holds = (a < b);
            default: cond_holds = (a >= b);
        endcase
    endfunction

    function automatic exp_t ref_cycle(input cyc_t c);
        exp_t        e;
        logic        r1;
        logic        r2;
        logic        ret;
        logic        hold;
        logic [31:0] v1;
        logic [31:0] jt;
        e   = '0;
        ret = 1'b0;
        jt  = '0;
        e.rs1 = c.op.rs1;
        e.rs2 = c.op.rs2;
        r1  = ready(c, c.op.rs1);
        r2  = ready(c, c.op.rs2);
        v1  = operand(c, c.op.rs1, c.rs1_data);
        if (c.op.kind == cf_branch) begin
            e.taken = (r1 && r2) ? cond_holds(c.op.f3, v1, operand(c, c.op.rs2, c.rs2_data))
                                 : bht_m[(model_pc >> 2) % `BHT_ENTRIES][1];
        end
        if (c.op.kind == cf_jalr) begin
            if (r1) begin
                jt = (v1 + c.op.imm) & ~32'd1;
            end else if (c.op.rs1 == 5'd1 && ras_cnt != 0) begin
                ret = 1'b1;
                jt  = ras_m[ras_tos];
            end else begin
                e.stall = 1'b1;
            end
        end
        hold    = c.stall || e.stall;
        e.push  = (c.op.kind == cf_jal) && (c.op.rd == 5'd1) && !c.redir.flush && !hold;
        e.pop   = ret && !c.redir.flush && !hold;
        e.instr = e.stall ? `NOP : encode(c.op);
        if (c.redir.flush) e.next_pc = c.redir.pc;
        else if (hold) e.next_pc = model_pc;
        else if (c.op.kind == cf_jal || e.taken) e.next_pc = model_pc + c.op.imm;
        else if (c.op.kind == cf_jalr) e.next_pc = jt;
        else e.next_pc = model_pc + 4;
        return e;
    endfunction

    ////////////////////////////////////////////////////////////
    // drive, check, compare
    ////////////////////////////////////////////////////////////

    task automatic drive(input cyc_t c);
        instr_i      = encode(c.op);
        rs1_data_i   = c.rs1_data;
        rs2_data_i   = c.rs2_data;
        mem_result_i = c.mem_res;
        wb_result_i  = c.wb_res;
        id_hz_i      = c.id;
        ex_hz_i      = c.ex;
        mem_hz_i     = c.mem;
        wb_hz_i      = c.wb;
        stall_i      = c.stall;
        redirect_i   = c.redir;
        train_i      = c.train;
    endtask

    // called at a falling edge, returns at the next one
    task automatic run_cycle(input cyc_t c);
        chk_t k;
        int   idx;
        drive(c);
        #1;
        k.e         = ref_cycle(c);
        k.cur_pc    = model_pc;
        k.got_pc    = pc_o;
        k.got_instr = instr_o;
        k.got_taken = taken_o;
        k.got_stall = stall_o;
        k.got_rs1   = rs1_addr_o;
        k.got_rs2   = rs2_addr_o;
        seen_stall  = stall_o;
        chk_q.push_back(k);
        if (k.e.push) begin
            ras_tos        = (ras_tos + 1) % `RAS_DEPTH;
            ras_m[ras_tos] = model_pc + 4;
            ras_cnt        = (ras_cnt < `RAS_DEPTH) ? ras_cnt + 1 : ras_cnt;
        end else if (k.e.pop) begin
            ras_tos = (ras_tos + `RAS_DEPTH - 1) % `RAS_DEPTH;
            ras_cnt = ras_cnt - 1;
        end
        if (c.train.valid) begin
            idx = (c.train.pc >> 2) % `BHT_ENTRIES;
            if (c.train.taken && bht_m[idx] != 2'b11) begin
                bht_m[idx] = bht_m[idx] + 2'b01;
            end else if (!c.train.taken && bht_m[idx] != 2'b00) begin
                bht_m[idx] = bht_m[idx] - 2'b01;
            end
        end
        model_pc = k.e.next_pc;
        @(negedge clk);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // id writer moves on after a few cycles, stall must clear then
    task automatic wait_stall_release(input cyc_t c, input int busy);
        int n;
        n          = 0;
        seen_stall = 1'b1;
        while (seen_stall && n < 10) begin
            if (n == busy) c.id = '0;
            run_cycle(c);
            n++;
        end
        if (seen_stall) begin
            err_cnt++;
            $display("timeout: stall_o stayed high after the id hazard cleared");
        end
    endtask

    always @(posedge clk) begin : compare_proc
        chk_t k;
        #1;
        if (chk_q.size() > 0) begin
            k = chk_q.pop_front();
            check_val("pc_o", k.got_pc, k.cur_pc);
            check_val("taken_o", k.got_taken, k.e.taken);
            check_val("stall_o", k.got_stall, k.e.stall);
            check_val("instr_o", k.got_instr, k.e.instr);
            check_val("rs1_addr_o", k.got_rs1, k.e.rs1);
            check_val("rs2_addr_o", k.got_rs2, k.e.rs2);
            check_val("pc_o next", pc_o, k.e.next_pc);
        end
    end

    initial begin : main
        cyc_t        c;
        cyc_t        t;
        logic [31:0] bpc;
        int          n;
        void'($urandom(34494));
        rst_n_i  = 1'b0;
        drive(idle_cycle());
        model_pc = `RESET_PC;
        ras_tos  = 0;
        ras_cnt  = 0;
        for (n = 0; n < `BHT_ENTRIES; n++) bht_m[n] = 2'b01;
        repeat (5) @(negedge clk);
        rst_n_i = 1'b1;

        // sequential fetch and back-pressure
        for (n = 0; n < 4; n++) run_cycle(idle_cycle());
        c = idle_cycle();
        c.stall = 1'b1;
        run_cycle(c);
        run_cycle(c);
        run_cycle(idle_cycle());

        // jal, then jalr from regfile and from mem
        c = idle_cycle();
        c.op.kind = cf_jal;
        c.op.rd   = 5'd5;
        c.op.imm  = rand_imm(21);
        run_cycle(c);
        for (n = 0; n < 2; n++) begin
            c = idle_cycle();
            c.op.kind  = cf_jalr;
            c.op.rs1   = 5'(5 + $urandom % 20);
            c.op.imm   = rand_imm(12);
            c.rs1_data = $urandom;
            c.mem_res  = $urandom;
            if (n == 1) c.mem = {c.op.rs1, 1'b1, 1'b0};
            run_cycle(c);
        end

        // resolved branches with forwarding
        for (n = 0; n < 40; n++) begin
            c = idle_cycle();
            c.op.kind  = cf_branch;
            c.op.f3    = 3'($urandom % 6);
            if (c.op.f3 > 3'd1) c.op.f3 = c.op.f3 + 3'd2;
            c.op.rs1   = 5'(1 + $urandom % 31);
            c.op.rs2   = 5'(1 + $urandom % 31);
            c.op.imm   = rand_imm(13);
            c.rs1_data = $urandom;
            c.rs2_data = ($urandom % 4 == 0) ? c.rs1_data : $urandom;
            c.mem_res  = ($urandom % 2) ? c.rs2_data : $urandom;
            c.wb_res   = ($urandom % 2) ? c.rs1_data : $urandom;
            c.ex       = {5'($urandom), 1'b1, 1'b0};
            c.mem      = rand_hz(c.op.rs1, c.op.rs2);
            c.wb       = rand_hz(c.op.rs1, c.op.rs2);
            c.stall    = ($urandom % 8 == 0);
            run_cycle(c);
        end

        // prediction before and after training
        bpc = model_pc;
        c = idle_cycle();
        c.op.kind  = cf_branch;
        c.op.rs1   = 5'd7;
        c.op.rs2   = 5'd8;
        c.op.imm   = 32'd64;
        c.rs1_data = 32'd5;
        c.rs2_data = 32'd5;
        c.id       = {5'd7, 1'b1, 1'b0};
        run_cycle(c);
        t = idle_cycle();
        t.train = {1'b1, bpc, 1'b1};
        run_cycle(t);
        run_cycle(t);
        t = idle_cycle();
        t.redir = {1'b1, bpc};
        run_cycle(t);
        c.id = '0;
        c.ex = {5'd8, 1'b1, 1'b1};
        // a resolved compare would fall through here
        c.rs2_data = 32'd6;
        run_cycle(c);

        // call and return, then return with the stack empty
        c = idle_cycle();
        c.op.kind = cf_jal;
        c.op.rd   = 5'd1;
        c.op.imm  = 32'd256;
        run_cycle(c);
        c = idle_cycle();
        c.op.kind  = cf_jalr;
        c.op.rs1   = 5'd1;
        c.rs1_data = 32'h0000_0400;
        c.id       = {5'd1, 1'b1, 1'b0};
        run_cycle(c);
        wait_stall_release(c, 3);

        // flush beats stall_i with a jal, and stall_o with a jalr
        c = idle_cycle();
        c.op.kind = cf_jal;
        c.op.rd   = 5'd1;
        c.op.imm  = 32'd512;
        c.stall   = 1'b1;
        c.redir   = {1'b1, 32'h0000_1000};
        run_cycle(c);
        c = idle_cycle();
        c.op.kind = cf_jalr;
        c.op.rs1  = 5'd1;
        c.id      = {5'd1, 1'b1, 1'b0};
        c.redir   = {1'b1, 32'h0000_2000};
        run_cycle(c);
        run_cycle(idle_cycle());
        run_cycle(idle_cycle());

        n = 0;
        while (chk_q.size() != 0 && n < 4) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (chk_q.size() != 0) begin
            err_cnt++;
            $display("timeout: pending checks were never compared");
        end
        $display("errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+source
source/rv_isa_pkg.sv
source/pipe_pkg.sv
source/mini_decode.sv
source/fetch_control.sv
source/branch_predictor.sv
source/branch_resolve.sv
source/pc_unit.sv
source/fetch_stage.sv
verif/fetch_tb.sv
